/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_rv_core
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := FAIL: see errors above
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test failed"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
hdl/rv_pkg.sv
hdl/reg_file.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/hazard_ctrl.sv
hdl/execute_stage.sv
hdl/mem_stage.sv
hdl/rv_core.sv
tb/rv_checker.sv
tb/tb_rv_core.sv

/* hdl/decode_stage.sv */
`default_nettype none

module decode_stage (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire  [rv_pkg::XLEN-1:0]        i_instr,
    input  wire                            i_hold,
    input  wire                            i_bubble,
    output logic [rv_pkg::REG_ADDR_W-1:0]  o_rs1_idx,
    output logic [rv_pkg::REG_ADDR_W-1:0]  o_rs2_idx,
    input  wire  [rv_pkg::XLEN-1:0]        i_rs1_data,
    input  wire  [rv_pkg::XLEN-1:0]        i_rs2_data,
    input  wire                            i_wb_we,
    input  wire  [rv_pkg::REG_ADDR_W-1:0]  i_wb_idx,
    input  wire  [rv_pkg::XLEN-1:0]        i_wb_data,
    output rv_pkg::alu_op_e                o_ex_alu_op,
    output logic                           o_ex_use_imm,
    output logic [rv_pkg::XLEN-1:0]        o_ex_imm,
    output logic [rv_pkg::XLEN-1:0]        o_ex_rs1_data,
    output logic [rv_pkg::XLEN-1:0]        o_ex_rs2_data,
    output logic [rv_pkg::REG_ADDR_W-1:0]  o_ex_rs1_idx,
    output logic [rv_pkg::REG_ADDR_W-1:0]  o_ex_rs2_idx,
    output logic [rv_pkg::REG_ADDR_W-1:0]  o_ex_rd_idx,
    output logic                           o_ex_reg_we,
    output logic                           o_ex_mem_re,
    output logic                           o_ex_mem_we
);
    import rv_pkg::*;

    opcode_e               opcode;
    alu_op_e               alu_op;
    logic                  reg_we, mem_re, mem_we, use_imm;
    logic                  rs1_used, rs2_used;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rd_idx;
    logic [XLEN-1:0]       rs1_val, rs2_val;

    assign opcode = opcode_e'(i_instr[6:0]);

    always_comb begin
        reg_we   = 1'b0;
        mem_re   = 1'b0;
        mem_we   = 1'b0;
        use_imm  = 1'b0;
        rs1_used = 1'b0;
        rs2_used = 1'b0;
        imm      = imm_i(i_instr);
        alu_op   = ALU_ADD; // address calc for loads and stores
        case (opcode)
            OP_REG: begin
                reg_we   = 1'b1;
                rs1_used = 1'b1;
                rs2_used = 1'b1;
            end
            OP_IMM, OP_LOAD: begin
                reg_we   = 1'b1;
                mem_re   = (opcode == OP_LOAD);
                use_imm  = 1'b1;
                rs1_used = 1'b1;
            end
            OP_STORE: begin
                mem_we   = 1'b1;
                use_imm  = 1'b1;
                imm      = imm_s(i_instr);
                rs1_used = 1'b1;
                rs2_used = 1'b1;
            end
            default: ; // unsupported, goes down as a bubble
        endcase
        if (opcode == OP_REG || opcode == OP_IMM) begin
            case (i_instr[14:12])
                3'b000:  alu_op = (opcode == OP_REG && i_instr[30]) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = i_instr[30] ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                3'b111:  alu_op = ALU_AND;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    // unused sources read as x0 so they never trip a hazard
    assign o_rs1_idx = rs1_used ? rs1_of(i_instr) : '0;
    assign o_rs2_idx = rs2_used ? rs2_of(i_instr) : '0;
    assign rd_idx    = reg_we ? rd_of(i_instr) : '0;

    // same-cycle writeback bypass
    assign rs1_val = (i_wb_we && i_wb_idx != '0 && i_wb_idx == o_rs1_idx) ? i_wb_data : i_rs1_data;
    assign rs2_val = (i_wb_we && i_wb_idx != '0 && i_wb_idx == o_rs2_idx) ? i_wb_data : i_rs2_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_ex_reg_we  <= 1'b0;
            o_ex_mem_re  <= 1'b0;
            o_ex_mem_we  <= 1'b0;
            o_ex_rd_idx  <= '0;
            o_ex_rs1_idx <= '0;
            o_ex_rs2_idx <= '0;
        end else if (!i_hold) begin
            o_ex_reg_we  <= reg_we & ~i_bubble; // load-use bubble
            o_ex_mem_re  <= mem_re & ~i_bubble;
            o_ex_mem_we  <= mem_we & ~i_bubble;
            o_ex_rd_idx  <= i_bubble ? '0 : rd_idx;
            o_ex_rs1_idx <= i_bubble ? '0 : o_rs1_idx;
            o_ex_rs2_idx <= i_bubble ? '0 : o_rs2_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_hold) begin
            o_ex_alu_op   <= alu_op;
            o_ex_use_imm  <= use_imm;
            o_ex_imm      <= imm;
            o_ex_rs1_data <= rs1_val;
            o_ex_rs2_data <= rs2_val;
        end
    end

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
`default_nettype none

module execute_stage (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            i_freeze,
    input  var   rv_pkg::alu_op_e          i_alu_op,
    input  wire                            i_use_imm,
    input  wire  [rv_pkg::XLEN-1:0]        i_imm,
    input  wire  [rv_pkg::XLEN-1:0]        i_rs1_data,
    input  wire  [rv_pkg::XLEN-1:0]        i_rs2_data,
    input  wire  [rv_pkg::REG_ADDR_W-1:0]  i_rd_idx,
    input  wire                            i_reg_we,
    input  wire                            i_mem_re,
    input  wire                            i_mem_we,
    input  var   rv_pkg::fwd_sel_e         i_fwd_a,
    input  var   rv_pkg::fwd_sel_e         i_fwd_b,
    input  wire  [rv_pkg::XLEN-1:0]        i_mem_alu_result,
    input  wire  [rv_pkg::XLEN-1:0]        i_wb_data,
    output logic [rv_pkg::XLEN-1:0]        o_mem_alu_result,
    output logic [rv_pkg::XLEN-1:0]        o_mem_store_data,
    output logic [rv_pkg::REG_ADDR_W-1:0]  o_mem_rd_idx,
    output logic                           o_mem_reg_we,
    output logic                           o_mem_re,
    output logic                           o_mem_we
);
    import rv_pkg::*;

    logic [XLEN-1:0] op_a, op_b;
    logic [XLEN-1:0] rs2_fwd;
    logic [XLEN-1:0] alu_result;

    function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                input logic [XLEN-1:0] reg_val,
                                                input logic [XLEN-1:0] exmem_val,
                                                input logic [XLEN-1:0] memwb_val);
        case (sel)
            FWD_EXMEM: return exmem_val;
            FWD_MEMWB: return memwb_val;
            default:   return reg_val;
        endcase
    endfunction

    always_comb begin
        op_a    = fwd_mux(i_fwd_a, i_rs1_data, i_mem_alu_result, i_wb_data);
        rs2_fwd = fwd_mux(i_fwd_b, i_rs2_data, i_mem_alu_result, i_wb_data);
        op_b    = i_use_imm ? i_imm : rs2_fwd;
    end

    always_comb begin
        case (i_alu_op)
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLL: alu_result = op_a << op_b[4:0]; // only low five bits shift
            ALU_SRL: alu_result = op_a >> op_b[4:0];
            ALU_SRA: alu_result = $signed(op_a) >>> op_b[4:0];
            default: alu_result = op_a + op_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_mem_rd_idx <= '0;
            o_mem_reg_we <= 1'b0;
            o_mem_re     <= 1'b0;
            o_mem_we     <= 1'b0;
        end else if (!i_freeze) begin
            o_mem_rd_idx <= i_rd_idx;
            o_mem_reg_we <= i_reg_we;
            o_mem_re     <= i_mem_re;
            o_mem_we     <= i_mem_we;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_freeze) begin
            o_mem_alu_result <= alu_result;
            o_mem_store_data <= rs2_fwd; // forwarded rs2 for sw
        end
    end

endmodule

`default_nettype wire

/* hdl/fetch_stage.sv */
`default_nettype none

module fetch_stage #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       i_hold,
    output logic [rv_pkg::XLEN-3:0]   o_imem_addr,
    input  wire  [rv_pkg::XLEN-1:0]   i_imem_rdata,
    output logic [rv_pkg::XLEN-1:0]   o_instr
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc;

    assign o_imem_addr = pc[XLEN-1:2]; // word address, imem answers same cycle

    // pc and IF/ID move together, held on load-use or freeze
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= RESET_PC;
            o_instr <= NOP_INSTR;
        end else if (!i_hold) begin
            pc      <= pc + XLEN'(4);
            o_instr <= i_imem_rdata;
        end
    end

endmodule

`default_nettype wire

/* hdl/hazard_ctrl.sv */
`default_nettype none

module hazard_ctrl (
    input  wire [rv_pkg::REG_ADDR_W-1:0] i_id_rs1_idx,
    input  wire [rv_pkg::REG_ADDR_W-1:0] i_id_rs2_idx,
    input  wire [rv_pkg::REG_ADDR_W-1:0] i_ex_rs1_idx,
    input  wire [rv_pkg::REG_ADDR_W-1:0] i_ex_rs2_idx,
    input  wire [rv_pkg::REG_ADDR_W-1:0] i_ex_rd_idx,
    input  wire                          i_ex_mem_re,
    input  wire [rv_pkg::REG_ADDR_W-1:0] i_mem_rd_idx,
    input  wire                          i_mem_reg_we,
    input  wire [rv_pkg::REG_ADDR_W-1:0] i_wb_rd_idx,
    input  wire                          i_wb_reg_we,
    input  wire                          i_dmem_valid,
    input  wire                          i_dmem_ready,
    output rv_pkg::fwd_sel_e             o_fwd_a,
    output rv_pkg::fwd_sel_e             o_fwd_b,
    output logic                         o_hold_front,
    output logic                         o_bubble_id,
    output logic                         o_freeze
);
    import rv_pkg::*;

    logic load_use;

    // youngest producer wins, a producer writing x0 never forwards
    function automatic fwd_sel_e fwd_pick(input logic [REG_ADDR_W-1:0] src);
        if (i_mem_reg_we && i_mem_rd_idx != '0 && i_mem_rd_idx == src)
            return FWD_EXMEM;
        if (i_wb_reg_we && i_wb_rd_idx != '0 && i_wb_rd_idx == src)
            return FWD_MEMWB;
        return FWD_NONE;
    endfunction

    always_comb begin
        o_fwd_a = fwd_pick(i_ex_rs1_idx);
        o_fwd_b = fwd_pick(i_ex_rs2_idx);
        a_no_x0_fwd: assert ((i_ex_rs1_idx != '0 || o_fwd_a == FWD_NONE) &&
                             (i_ex_rs2_idx != '0 || o_fwd_b == FWD_NONE))
            else $error("forward select set for x0 source");
    end

    // load result only exists after MEM so the consumer waits one cycle
    assign load_use = i_ex_mem_re && i_ex_rd_idx != '0 &&
                      (i_ex_rd_idx == i_id_rs1_idx || i_ex_rd_idx == i_id_rs2_idx);

    assign o_freeze     = i_dmem_valid && !i_dmem_ready; // whole pipe waits on dmem
    assign o_bubble_id  = load_use;
    assign o_hold_front = load_use || o_freeze;

endmodule

`default_nettype wire

/* hdl/mem_stage.sv */
`default_nettype none

module mem_stage (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            i_freeze,
    input  wire  [rv_pkg::XLEN-1:0]        i_alu_result,
    input  wire  [rv_pkg::XLEN-1:0]        i_store_data,
    input  wire  [rv_pkg::REG_ADDR_W-1:0]  i_rd_idx,
    input  wire                            i_reg_we,
    input  wire                            i_mem_re,
    input  wire                            i_mem_we,
    output logic                           o_dmem_valid,
    output logic                           o_dmem_we,
    output logic [rv_pkg::XLEN-3:0]        o_dmem_addr,
    output logic [rv_pkg::XLEN-1:0]        o_dmem_wdata,
    input  wire                            i_dmem_ready,
    input  wire  [rv_pkg::XLEN-1:0]        i_dmem_rdata,
    output logic                           o_wb_we,
    output logic [rv_pkg::REG_ADDR_W-1:0]  o_wb_idx,
    output logic [rv_pkg::XLEN-1:0]        o_wb_data
);
    import rv_pkg::*;

    // request comes straight off EX/MEM, stable while frozen
    assign o_dmem_valid = i_mem_re | i_mem_we;
    assign o_dmem_we    = i_mem_we;
    assign o_dmem_addr  = i_alu_result[XLEN-1:2];
    assign o_dmem_wdata = i_store_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_wb_we  <= 1'b0;
            o_wb_idx <= '0;
        end else if (!i_freeze) begin
            o_wb_we  <= i_reg_we;
            o_wb_idx <= i_rd_idx;
        end
    end

    // load data sampled on the transfer edge
    always_ff @(posedge clk) begin
        if (!i_freeze)
            o_wb_data <= i_mem_re ? i_dmem_rdata : i_alu_result;
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (o_dmem_valid && !i_dmem_ready) |=>
            o_dmem_valid && $stable(o_dmem_we) && $stable(o_dmem_addr) && $stable(o_dmem_wdata));

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`default_nettype none

module reg_file (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire  [rv_pkg::REG_ADDR_W-1:0]  i_rs1_idx,
    input  wire  [rv_pkg::REG_ADDR_W-1:0]  i_rs2_idx,
    output logic [rv_pkg::XLEN-1:0]        o_rs1_data,
    output logic [rv_pkg::XLEN-1:0]        o_rs2_data,
    input  wire                            i_we,
    input  wire  [rv_pkg::REG_ADDR_W-1:0]  i_wr_idx,
    input  wire  [rv_pkg::XLEN-1:0]        i_wr_data
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [0:2**REG_ADDR_W-1];

    assign o_rs1_data = regs[i_rs1_idx];
    assign o_rs2_data = regs[i_rs2_idx];

    // x0 cleared at reset and never written afterwards
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            regs[0] <= '0;
        else if (i_we && i_wr_idx != '0) // x0 writes dropped
            regs[i_wr_idx] <= i_wr_data;
    end

    // x0 storage stays zero whatever the write port does
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (i_rs1_idx != '0 || o_rs1_data == '0) && (i_rs2_idx != '0 || o_rs2_data == '0));

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`default_nettype none

module rv_core #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = 32'h0000_0000
) (
    input  wire                       clk,
    input  wire                       rst_n,
    output logic [rv_pkg::XLEN-3:0]   o_imem_addr,
    input  wire  [rv_pkg::XLEN-1:0]   i_imem_rdata,
    output logic                      o_dmem_valid,
    output logic                      o_dmem_we,
    output logic [rv_pkg::XLEN-3:0]   o_dmem_addr,
    output logic [rv_pkg::XLEN-1:0]   o_dmem_wdata,
    input  wire                       i_dmem_ready,
    input  wire  [rv_pkg::XLEN-1:0]   i_dmem_rdata
);
    import rv_pkg::*;

    logic [XLEN-1:0]       if_instr;
    logic [REG_ADDR_W-1:0] id_rs1_idx, id_rs2_idx;
    logic [XLEN-1:0]       rf_rs1_data, rf_rs2_data;

    alu_op_e               ex_alu_op; // ID/EX contents
    logic                  ex_use_imm;
    logic [XLEN-1:0]       ex_imm, ex_rs1_data, ex_rs2_data;
    logic [REG_ADDR_W-1:0] ex_rs1_idx, ex_rs2_idx, ex_rd_idx;
    logic                  ex_reg_we, ex_mem_re, ex_mem_we;

    logic [XLEN-1:0]       mem_alu_result, mem_store_data; // EX/MEM contents
    logic [REG_ADDR_W-1:0] mem_rd_idx;
    logic                  mem_reg_we, mem_re, mem_we;

    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_idx;
    logic [XLEN-1:0]       wb_data;

    fwd_sel_e              fwd_a, fwd_b;
    logic                  hold_front, bubble_id, freeze;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .rst_n(rst_n), .i_hold(hold_front),
        .o_imem_addr(o_imem_addr), .i_imem_rdata(i_imem_rdata), .o_instr(if_instr)
    );

    decode_stage u_decode (
        .clk(clk), .rst_n(rst_n), .i_instr(if_instr),
        .i_hold(freeze), .i_bubble(bubble_id),
        .o_rs1_idx(id_rs1_idx), .o_rs2_idx(id_rs2_idx),
        .i_rs1_data(rf_rs1_data), .i_rs2_data(rf_rs2_data),
        .i_wb_we(wb_we), .i_wb_idx(wb_idx), .i_wb_data(wb_data),
        .o_ex_alu_op(ex_alu_op), .o_ex_use_imm(ex_use_imm), .o_ex_imm(ex_imm),
        .o_ex_rs1_data(ex_rs1_data), .o_ex_rs2_data(ex_rs2_data),
        .o_ex_rs1_idx(ex_rs1_idx), .o_ex_rs2_idx(ex_rs2_idx), .o_ex_rd_idx(ex_rd_idx),
        .o_ex_reg_we(ex_reg_we), .o_ex_mem_re(ex_mem_re), .o_ex_mem_we(ex_mem_we)
    );

    reg_file u_reg_file (
        .clk(clk), .rst_n(rst_n),
        .i_rs1_idx(id_rs1_idx), .i_rs2_idx(id_rs2_idx),
        .o_rs1_data(rf_rs1_data), .o_rs2_data(rf_rs2_data),
        .i_we(wb_we), .i_wr_idx(wb_idx), .i_wr_data(wb_data)
    );

    hazard_ctrl u_hazard (
        .i_id_rs1_idx(id_rs1_idx), .i_id_rs2_idx(id_rs2_idx),
        .i_ex_rs1_idx(ex_rs1_idx), .i_ex_rs2_idx(ex_rs2_idx),
        .i_ex_rd_idx(ex_rd_idx), .i_ex_mem_re(ex_mem_re),
        .i_mem_rd_idx(mem_rd_idx), .i_mem_reg_we(mem_reg_we),
        .i_wb_rd_idx(wb_idx), .i_wb_reg_we(wb_we),
        .i_dmem_valid(o_dmem_valid), .i_dmem_ready(i_dmem_ready),
        .o_fwd_a(fwd_a), .o_fwd_b(fwd_b),
        .o_hold_front(hold_front), .o_bubble_id(bubble_id), .o_freeze(freeze)
    );

    execute_stage u_execute (
        .clk(clk), .rst_n(rst_n), .i_freeze(freeze),
        .i_alu_op(ex_alu_op), .i_use_imm(ex_use_imm), .i_imm(ex_imm),
        .i_rs1_data(ex_rs1_data), .i_rs2_data(ex_rs2_data), .i_rd_idx(ex_rd_idx),
        .i_reg_we(ex_reg_we), .i_mem_re(ex_mem_re), .i_mem_we(ex_mem_we),
        .i_fwd_a(fwd_a), .i_fwd_b(fwd_b),
        .i_mem_alu_result(mem_alu_result), .i_wb_data(wb_data),
        .o_mem_alu_result(mem_alu_result), .o_mem_store_data(mem_store_data),
        .o_mem_rd_idx(mem_rd_idx), .o_mem_reg_we(mem_reg_we),
        .o_mem_re(mem_re), .o_mem_we(mem_we)
    );

    mem_stage u_mem (
        .clk(clk), .rst_n(rst_n), .i_freeze(freeze),
        .i_alu_result(mem_alu_result), .i_store_data(mem_store_data),
        .i_rd_idx(mem_rd_idx), .i_reg_we(mem_reg_we),
        .i_mem_re(mem_re), .i_mem_we(mem_we),
        .o_dmem_valid(o_dmem_valid), .o_dmem_we(o_dmem_we),
        .o_dmem_addr(o_dmem_addr), .o_dmem_wdata(o_dmem_wdata),
        .i_dmem_ready(i_dmem_ready), .i_dmem_rdata(i_dmem_rdata),
        .o_wb_we(wb_we), .o_wb_idx(wb_idx), .o_wb_data(wb_data)
    );

endmodule

`default_nettype wire

/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

    // major opcodes still decoded, anything else is a bubble
    typedef enum logic [6:0] {
        OP_REG   = 7'b0110011,
        OP_IMM   = 7'b0010011,
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    // execute operand source
    typedef enum logic [1:0] {FWD_NONE, FWD_EXMEM, FWD_MEMWB} fwd_sel_e;

    function automatic logic [REG_ADDR_W-1:0] rd_of(input logic [XLEN-1:0] instr);
        return instr[11:7];
    endfunction

    function automatic logic [REG_ADDR_W-1:0] rs1_of(input logic [XLEN-1:0] instr);
        return instr[19:15];
    endfunction

    function automatic logic [REG_ADDR_W-1:0] rs2_of(input logic [XLEN-1:0] instr);
        return instr[24:20];
    endfunction

    function automatic logic [XLEN-1:0] imm_i(input logic [XLEN-1:0] instr);
        return {{20{instr[31]}}, instr[31:20]};
    endfunction

    function automatic logic [XLEN-1:0] imm_s(input logic [XLEN-1:0] instr);
        return {{20{instr[31]}}, instr[31:25], instr[11:7]};
    endfunction

endpackage

`default_nettype wire

/* tb/rv_cases.txt */
// columns: tag _ instruction _ expected store byte address _ expected store data
// tag 1 marks a sw whose transfer is checked, tag 0 an instruction only
0_ff900093_00000000_00000000 // addi x1, x0, -7
0_00300113_00000000_00000000 // addi x2, x0, 3
0_002081b3_00000000_00000000 // add  x3, x1, x2
1_04302023_00000040_fffffffc // sw   x3, 0x40(x0)
0_40218233_00000000_00000000 // sub  x4, x3, x2
0_402252b3_00000000_00000000 // sra  x5, x4, x2
1_04502223_00000044_ffffffff // sw   x5, 0x44(x0)
0_00225333_00000000_00000000 // srl  x6, x4, x2
0_002113b3_00000000_00000000 // sll  x7, x2, x2
0_0020a433_00000000_00000000 // slt  x8, x1, x2
0_007344b3_00000000_00000000 // xor  x9, x6, x7
0_00746533_00000000_00000000 // or   x10, x8, x7
0_0090f5b3_00000000_00000000 // and  x11, x1, x9
1_04602423_00000048_1fffffff // sw   x6, 0x48(x0)
1_04702623_0000004c_00000018 // sw   x7, 0x4c(x0)
1_04802823_00000050_00000001 // sw   x8, 0x50(x0)
1_04902a23_00000054_1fffffe7 // sw   x9, 0x54(x0)
1_04a02c23_00000058_00000019 // sw   x10, 0x58(x0)
1_04b02e23_0000005c_1fffffe1 // sw   x11, 0x5c(x0)
0_fff0c613_00000000_00000000 // xori x12, x1, -1
0_4010d693_00000000_00000000 // srai x13, x1, 1
0_ffa0a713_00000000_00000000 // slti x14, x1, -6
0_7f066793_00000000_00000000 // ori  x15, x12, 0x7f0
0_01e11813_00000000_00000000 // slli x16, x2, 30
1_06c02023_00000060_00000006 // sw   x12, 0x60(x0)
1_06d02223_00000064_fffffffc // sw   x13, 0x64(x0)
1_06e02423_00000068_00000001 // sw   x14, 0x68(x0)
1_06f02623_0000006c_000007f6 // sw   x15, 0x6c(x0)
1_07002823_00000070_c0000000 // sw   x16, 0x70(x0)
0_04402883_00000000_00000000 // lw   x17, 0x44(x0)
0_00588913_00000000_00000000 // addi x18, x17, 5 right behind the load
1_07202a23_00000074_00000004 // sw   x18, 0x74(x0)
0_06300013_00000000_00000000 // addi x0, x0, 99
1_06002c23_00000078_00000000 // sw   x0, 0x78(x0)

/* tb/rv_checker.sv */
`default_nettype none

module rv_checker (
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [29:0] i_imem_addr,
    input  wire         i_dmem_valid,
    input  wire         i_dmem_we,
    input  wire  [29:0] i_dmem_addr,
    input  wire  [31:0] i_dmem_wdata,
    input  wire         i_dmem_ready,
    input  wire  [31:0] i_exp_addr,
    input  wire  [31:0] i_exp_data,
    input  wire  [31:0] i_exp_count,
    output logic [31:0] o_store_idx,
    output logic [31:0] o_error_count,
    output logic        o_done
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [29:0] BOOT_WORD = 30'h0; // program image sits at word 0

    logic        was_waiting = 1'b0; // valid without ready on the last edge
    logic        prev_we;
    logic [29:0] prev_addr;
    logic [31:0] prev_wdata;
    logic [29:0] prev_imem_addr;
    logic [31:0] store_idx = '0;
    int          error_count = 0;

    assign o_store_idx   = store_idx;
    assign o_error_count = 32'(error_count);
    assign o_done        = (i_exp_count != '0) && (store_idx >= i_exp_count);

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Error: %0t %s expected %h got %h", $time, name, expected, actual);
        error_count++;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            if (i_dmem_valid == 1'b1)
                report_mismatch("o_dmem_valid", 32'd0, 32'd1);
            if (i_imem_addr != BOOT_WORD)
                report_mismatch("o_imem_addr", 32'(BOOT_WORD), 32'(i_imem_addr));
        end else begin
            if (was_waiting) begin // request and fetch must hold until ready
                if (i_dmem_valid != 1'b1)
                    report_mismatch("o_dmem_valid", 32'd1, 32'(i_dmem_valid));
                if (i_dmem_we != prev_we)
                    report_mismatch("o_dmem_we", 32'(prev_we), 32'(i_dmem_we));
                if (i_dmem_addr != prev_addr)
                    report_mismatch("o_dmem_addr", 32'(prev_addr), 32'(i_dmem_addr));
                if (i_dmem_wdata != prev_wdata)
                    report_mismatch("o_dmem_wdata", prev_wdata, i_dmem_wdata);
                if (i_imem_addr != prev_imem_addr)
                    report_mismatch("o_imem_addr", 32'(prev_imem_addr), 32'(i_imem_addr));
            end else if (i_imem_addr != prev_imem_addr &&
                         i_imem_addr != prev_imem_addr + 30'd1) begin
                report_mismatch("o_imem_addr", 32'(prev_imem_addr + 30'd1),
                                32'(i_imem_addr)); // pc steps one word or holds
            end
            if (i_dmem_valid && i_dmem_ready && i_dmem_we) begin
                if (store_idx >= i_exp_count) begin
                    $display("unexpected extra store at time %0t, word address %h",
                             $time, i_dmem_addr);
                    error_count++;
                end else begin
                    if (i_dmem_addr != i_exp_addr[31:2]) // compared as word address
                        report_mismatch("o_dmem_addr", 32'(i_exp_addr[31:2]),
                                        32'(i_dmem_addr));
                    if (i_dmem_wdata != i_exp_data)
                        report_mismatch("o_dmem_wdata", i_exp_data, i_dmem_wdata);
                end
                store_idx <= store_idx + 1;
            end
        end
        was_waiting    <= rst_n && i_dmem_valid && !i_dmem_ready;
        prev_we        <= i_dmem_we;
        prev_addr      <= i_dmem_addr;
        prev_wdata     <= i_dmem_wdata;
        prev_imem_addr <= i_imem_addr;
    end

endmodule

`default_nettype wire

/* tb/tb_rv_core.sv */
`default_nettype none

module tb_rv_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          MAX_CASES  = 64;
    localparam int          DMEM_WORDS = 256;
    localparam logic [31:0] NOP_WORD   = 32'h0000_0013; // addi x0, x0, 0

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic [29:0] imem_addr;
    logic [31:0] imem_rdata;
    logic        dmem_valid, dmem_we;
    logic [29:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_ready = 1'b0;
    logic [31:0] dmem_rdata = '0;

    logic [99:0] cases [0:MAX_CASES-1]; // tag, instruction, store address, store data
    logic [31:0] prog [0:MAX_CASES-1];
    logic [31:0] exp_addr [0:MAX_CASES-1];
    logic [31:0] exp_data [0:MAX_CASES-1];
    logic [31:0] dmem [0:DMEM_WORDS-1];
    int          prog_len = 0;
    logic [31:0] exp_count = '0;
    logic [31:0] store_idx, error_count, cur_addr, cur_data;
    logic        checks_done;
    integer      seed = 32'ha7be;
    int          low_run = 0; // ready low streak capped so memory always answers
    int          cycles = 0;
    int          limit;

    always #5 clk = ~clk;

    // program then NOPs answered in the same cycle
    assign imem_rdata = (imem_addr < 30'(prog_len)) ? prog[imem_addr[5:0]] : NOP_WORD;
    assign cur_addr   = (store_idx < 32'd64) ? exp_addr[store_idx[5:0]] : '0;
    assign cur_data   = (store_idx < 32'd64) ? exp_data[store_idx[5:0]] : '0;

    task automatic load_cases();
        int i;
        for (i = 0; i < MAX_CASES; i++)
            cases[i[5:0]] = {4'hf, 96'h0}; // end marker past the last line
        $readmemh("tb/rv_cases.txt", cases);
        while (prog_len < MAX_CASES && cases[prog_len[5:0]][99:96] != 4'hf) begin
            prog[prog_len[5:0]] = cases[prog_len[5:0]][95:64];
            if (cases[prog_len[5:0]][99:96] == 4'h1) begin
                exp_addr[exp_count[5:0]] = cases[prog_len[5:0]][63:32];
                exp_data[exp_count[5:0]] = cases[prog_len[5:0]][31:0];
                exp_count = exp_count + 1;
            end
            prog_len++;
        end
    endtask

    always @(posedge clk) begin : dmem_write
        int i;
        if (!rst_n) begin
            for (i = 0; i < DMEM_WORDS; i++)
                dmem[i[7:0]] <= 32'hbad0_0000 ^ 32'(i);
        end else if (dmem_valid && dmem_ready && dmem_we) begin
            dmem[dmem_addr[7:0]] <= dmem_wdata;
        end
    end

    always @(posedge clk) begin
        #1;
        if (low_run >= 3 || ($random(seed) & 3) != 0) begin
            dmem_ready = 1'b1;
            low_run    = 0;
        end else begin
            dmem_ready = 1'b0;
            low_run    = low_run + 1;
        end
        dmem_rdata = dmem[dmem_addr[7:0]]; // load data valid before the next edge
    end

    rv_core u_rv_core (
        .clk(clk), .rst_n(rst_n),
        .o_imem_addr(imem_addr), .i_imem_rdata(imem_rdata),
        .o_dmem_valid(dmem_valid), .o_dmem_we(dmem_we),
        .o_dmem_addr(dmem_addr), .o_dmem_wdata(dmem_wdata),
        .i_dmem_ready(dmem_ready), .i_dmem_rdata(dmem_rdata)
    );

    rv_checker u_checker (
        .clk(clk), .rst_n(rst_n), .i_imem_addr(imem_addr),
        .i_dmem_valid(dmem_valid), .i_dmem_we(dmem_we),
        .i_dmem_addr(dmem_addr), .i_dmem_wdata(dmem_wdata), .i_dmem_ready(dmem_ready),
        .i_exp_addr(cur_addr), .i_exp_data(cur_data), .i_exp_count(exp_count),
        .o_store_idx(store_idx), .o_error_count(error_count), .o_done(checks_done)
    );

    initial begin
        load_cases();
        limit = prog_len * 8 + 100; // worst case stall factor per instruction
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        while (!checks_done && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (!checks_done)
            $display("timeout after %0d cycles, only %0d of %0d stores seen",
                     cycles, store_idx, exp_count);
        else
            repeat (10) @(posedge clk); // room for a stray extra store
        #1;
        $display("stores checked: %0d of %0d, errors: %0d", store_idx, exp_count, error_count);
        if (checks_done && error_count == '0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
